/* hw/flow_pkg.sv */
`default_nettype none

package flow_pkg;

   // bus geometry
   localparam int data_w  = 32;
   localparam int n_slots = 4;
   localparam int slot_w  = 2;

   localparam int slot_in_a = 0;
   localparam int slot_in_b = 1;
   localparam int slot_alu0 = 2;
   localparam int slot_alu1 = 3;

   // alu config word, msb first: sela, selb, self_loop, fns
   localparam int fns_w         = 3;
   localparam int alu_conf_w    = 8;
   localparam int conf_sela_lsb = 6;
   localparam int conf_selb_lsb = 4;
   localparam int conf_loop_bit = 3;
   localparam int conf_fns_lsb  = 0;

   localparam int cfg_addr_w = 2;
   localparam logic [cfg_addr_w-1:0] cfg_alu0 = 2'd0;
   localparam logic [cfg_addr_w-1:0] cfg_alu1 = 2'd1;
   localparam logic [cfg_addr_w-1:0] cfg_out  = 2'd2;

   localparam logic [fns_w-1:0] fn_add     = 3'd0;
   localparam logic [fns_w-1:0] fn_sub     = 3'd1;
   localparam logic [fns_w-1:0] fn_cmp_sig = 3'd2;
   localparam logic [fns_w-1:0] fn_mux     = 3'd3;
   localparam logic [fns_w-1:0] fn_or      = 3'd4;
   localparam logic [fns_w-1:0] fn_and     = 3'd5;
   localparam logic [fns_w-1:0] fn_max     = 3'd6;
   localparam logic [fns_w-1:0] fn_min     = 3'd7;

   // input, two alus and output stage, plus one spare cycle
   localparam int out_fill = 7;

endpackage

`default_nettype wire

/* hw/cfg_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module cfg_bank
   import flow_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  cfg_we,
   input  logic [cfg_addr_w-1:0] cfg_addr,
   input  logic [alu_conf_w-1:0] cfg_data,
   input  logic                  cfg_commit,
   output logic [alu_conf_w-1:0] alu0_conf,
   output logic [alu_conf_w-1:0] alu1_conf,
   output logic [slot_w-1:0]     out_sel
);

   logic [alu_conf_w-1:0] shadow_alu0;
   logic [alu_conf_w-1:0] shadow_alu1;
   logic [alu_conf_w-1:0] shadow_out;

   // shadow words, written one at a time
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         shadow_alu0 <= '0;
         shadow_alu1 <= '0;
         shadow_out  <= '0;
      end else if (cfg_we) begin
         case (cfg_addr)
            cfg_alu0: shadow_alu0 <= cfg_data;
            cfg_alu1: shadow_alu1 <= cfg_data;
            cfg_out:  shadow_out  <= cfg_data;
            default: begin
               // address 3 is not mapped
            end
         endcase
      end
   end

   // active words switch together on commit
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         alu0_conf <= '0;
         alu1_conf <= '0;
         out_sel   <= '0;
      end else if (cfg_commit) begin
         alu0_conf <= shadow_alu0;
         alu1_conf <= shadow_alu1;
         // output stage only needs a slot index
         out_sel   <= shadow_out[slot_w-1:0];
      end
   end

endmodule

`default_nettype wire

/* hw/flow_in_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module flow_in_stage
   import flow_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              din_ld,
   input  logic [data_w-1:0] din_a,
   input  logic [data_w-1:0] din_b,
   output logic [data_w-1:0] slot_a,
   output logic [data_w-1:0] slot_b
);

   // operands stay put between loads so feedback loops see fixed inputs
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         slot_a <= '0;
         slot_b <= '0;
      end else if (din_ld) begin
         slot_a <= din_a;
         slot_b <= din_b;
      end
   end

endmodule

`default_nettype wire

/* hw/alu_lite.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_lite
   import flow_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      run,
   input  logic [n_slots*data_w-1:0] flow,
   input  logic [alu_conf_w-1:0]     conf,
   output logic [data_w-1:0]         result
);

   logic [slot_w-1:0] sela;
   logic [slot_w-1:0] selb;
   logic              self_loop;
   logic [fns_w-1:0]  fns;

   logic [data_w-1:0] op_a;
   logic [data_w-1:0] op_b;
   logic [data_w-1:0] op_a_reg;
   logic [data_w-1:0] op_b_reg;
   logic [data_w-1:0] op_a_int;

   logic              sub_op;
   logic              sign_ext;
   logic [data_w:0]   a_ext;
   logic [data_w:0]   b_ext;
   logic [data_w:0]   sum;
   logic [data_w-1:0] result_nxt;

   // config fields
   assign sela      = conf[conf_sela_lsb +: slot_w];
   assign selb      = conf[conf_selb_lsb +: slot_w];
   assign self_loop = conf[conf_loop_bit];
   assign fns       = conf[conf_fns_lsb +: fns_w];

   // operand pick from the bus
   assign op_a = flow[sela*data_w +: data_w];
   assign op_b = flow[selb*data_w +: data_w];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         op_a_reg <= '0;
         op_b_reg <= '0;
      end else if (run) begin
         op_a_reg <= op_a;
         op_b_reg <= op_b;
      end
   end

   // in self-loop mode raw a turns into a control word
   assign op_a_int = self_loop ? result : op_a_reg;

   always_comb begin
      sub_op   = 1'b0;
      sign_ext = 1'b0;
      case (fns)
         fn_sub: begin
            sub_op = 1'b1;
         end
         fn_cmp_sig, fn_max, fn_min: begin
            sub_op   = 1'b1;
            sign_ext = 1'b1;
         end
         default: begin
            sub_op = 1'b0;
         end
      endcase
   end

   // one 33 bit adder, b + a or b - a
   assign a_ext = {sign_ext & op_a_int[data_w-1], op_a_int};
   assign b_ext = {sign_ext & op_b_reg[data_w-1], op_b_reg};
   assign sum   = b_ext + (a_ext ^ {(data_w+1){sub_op}}) + {{data_w{1'b0}}, sub_op};

   always_comb begin
      result_nxt = sum[data_w-1:0];
      case (fns)
         fn_add: begin
            if (self_loop && op_a_reg[data_w-1])
               result_nxt = op_b_reg;
         end
         fn_sub: begin
            result_nxt = sum[data_w-1:0];
         end
         fn_cmp_sig: begin
            // msb carries b < a
            result_nxt = {sum[data_w], sum[data_w-2:0]};
         end
         fn_mux: begin
            if (op_a_reg[data_w-1])
               result_nxt = op_b_reg;
            else if (self_loop)
               result_nxt = result;
            else
               result_nxt = '0;
         end
         fn_or: begin
            result_nxt = op_a_int | op_b_reg;
         end
         fn_and: begin
            result_nxt = op_a_int & op_b_reg;
         end
         fn_max: begin
            if (self_loop && op_a_reg[data_w-1])
               result_nxt = result;
            else if (!sum[data_w])
               result_nxt = op_b_reg;
            else
               result_nxt = op_a_int;
         end
         fn_min: begin
            if (self_loop && op_a_reg[data_w-1])
               result_nxt = result;
            else if (!sum[data_w])
               result_nxt = op_a_int;
            else
               result_nxt = op_b_reg;
         end
         default: begin
            result_nxt = sum[data_w-1:0];
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         result <= '0;
      else if (run)
         result <= result_nxt;
   end

endmodule

`default_nettype wire

/* hw/flow_out_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module flow_out_stage
   import flow_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      run,
   input  logic [n_slots*data_w-1:0] flow,
   input  logic [slot_w-1:0]         out_sel,
   output logic [data_w-1:0]         dout,
   output logic                      out_valid
);

   logic [$clog2(out_fill+1)-1:0] fill_cnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         dout <= '0;
      else if (run)
         dout <= flow[out_sel*data_w +: data_w];
   end

   // run cycles seen so far, saturating
   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         fill_cnt <= '0;
      else if (!run)
         fill_cnt <= '0;
      else if (fill_cnt != out_fill)
         fill_cnt <= fill_cnt + 1'b1;
   end

   // drops in the same cycle run goes low
   assign out_valid = run && (fill_cnt == out_fill);

endmodule

`default_nettype wire

/* hw/flow_top.sv */
`timescale 1ns/10ps
`default_nettype none

module flow_top
   import flow_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  cfg_we,
   input  logic [cfg_addr_w-1:0] cfg_addr,
   input  logic [alu_conf_w-1:0] cfg_data,
   input  logic                  cfg_commit,
   input  logic                  din_ld,
   input  logic [data_w-1:0]     din_a,
   input  logic [data_w-1:0]     din_b,
   input  logic                  run,
   output logic [data_w-1:0]     dout,
   output logic                  out_valid
);

   wire [n_slots*data_w-1:0] flow;
   wire [alu_conf_w-1:0]     alu0_conf;
   wire [alu_conf_w-1:0]     alu1_conf;
   wire [slot_w-1:0]         out_sel;

   cfg_bank u_cfg (
      .clk        (clk),
      .rst        (rst),
      .cfg_we     (cfg_we),
      .cfg_addr   (cfg_addr),
      .cfg_data   (cfg_data),
      .cfg_commit (cfg_commit),
      .alu0_conf  (alu0_conf),
      .alu1_conf  (alu1_conf),
      .out_sel    (out_sel)
   );

   flow_in_stage u_in (
      .clk    (clk),
      .rst    (rst),
      .din_ld (din_ld),
      .din_a  (din_a),
      .din_b  (din_b),
      .slot_a (flow[slot_in_a*data_w +: data_w]),
      .slot_b (flow[slot_in_b*data_w +: data_w])
   );

   alu_lite alu0 (
      .clk    (clk),
      .rst    (rst),
      .run    (run),
      .flow   (flow),
      .conf   (alu0_conf),
      .result (flow[slot_alu0*data_w +: data_w])
   );

   alu_lite alu1 (
      .clk    (clk),
      .rst    (rst),
      .run    (run),
      .flow   (flow),
      .conf   (alu1_conf),
      .result (flow[slot_alu1*data_w +: data_w])
   );

   flow_out_stage u_out (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .flow      (flow),
      .out_sel   (out_sel),
      .dout      (dout),
      .out_valid (out_valid)
   );

endmodule

`default_nettype wire

/* tb/flow_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module flow_checker
   import flow_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic [data_w-1:0] dout,
   input  logic              out_valid,
   input  int                test_num,
   input  logic              step_mode,
   input  logic [data_w-1:0] expected,
   input  int                exp_valid,
   input  logic              test_end,
   input  logic              all_done,
   output int                n_pass,
   output int                n_fail
);

   logic [data_w-1:0] last;
   int                n_valid;
   int                n_bad;

   always @(posedge clk) begin
      if (rst) begin
         n_pass  = 0;
         n_fail  = 0;
         n_valid = 0;
         n_bad   = 0;
         last    = '0;
      end else begin
         if (out_valid) begin
            // accumulating rows move by exactly one b per sample
            if (step_mode && n_valid > 0 && dout - last !== expected) begin
               $display("Fail at %0t: test %0d stepped %h to %h, expected step %h",
                        $time, test_num, last, dout, expected);
               n_bad++;
            end
            last = dout;
            n_valid++;
         end
         if (test_end) begin
            if (n_valid == 0) begin
               $display("test %0d: out_valid never went high during the run", test_num);
               n_bad++;
            end else if (n_valid != exp_valid) begin
               $display("Fail at %0t: test %0d out_valid high for %0d cycles, expected %0d",
                        $time, test_num, n_valid, exp_valid);
               n_bad++;
            end
            if (!step_mode && n_valid > 0 && last !== expected) begin
               $display("Fail at %0t: test %0d dout %h, expected %h",
                        $time, test_num, last, expected);
               n_bad++;
            end
            if (n_bad == 0) begin
               $display("test %0d passed, %0d valid samples", test_num, n_valid);
               n_pass++;
            end else begin
               $display("test %0d failed", test_num);
               n_fail++;
            end
            n_valid = 0;
            n_bad   = 0;
         end
      end
   end

   always @(posedge all_done)
      $display("%0d tests passed, %0d tests failed", n_pass, n_fail);

endmodule

`default_nettype wire

/* tb/tb_flow_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_flow_top
   import flow_pkg::*;
();

   localparam int max_rows   = 24;
   localparam int mode_fixed = 0;
   localparam int mode_model = 1;
   localparam int mode_step  = 2;

   logic                  clk;
   logic                  rst;
   logic                  cfg_we;
   logic [cfg_addr_w-1:0] cfg_addr;
   logic [alu_conf_w-1:0] cfg_data;
   logic                  cfg_commit;
   logic                  din_ld;
   logic [data_w-1:0]     din_a;
   logic [data_w-1:0]     din_b;
   logic                  run;
   logic [data_w-1:0]     dout;
   logic                  out_valid;

   int                    cur_test;
   logic                  cur_step;
   logic [data_w-1:0]     cur_exp;
   int                    cur_valid;
   logic                  test_end;
   logic                  all_done;
   int                    n_pass;
   int                    n_fail;

   // one entry per test; model rows keep a function code in row_exp
   logic [alu_conf_w-1:0] row_c0 [max_rows];
   logic [alu_conf_w-1:0] row_c1 [max_rows];
   logic [slot_w-1:0]     row_osel [max_rows];
   logic [data_w-1:0]     row_a [max_rows];
   logic [data_w-1:0]     row_b [max_rows];
   int                    row_len [max_rows];
   int                    row_mode [max_rows];
   logic                  row_commit [max_rows];
   logic [data_w-1:0]     row_exp [max_rows];
   int                    n_rows;

   logic [31:0]           lfsr;
   int                    cycle_cnt;
   int                    cycle_limit;

   flow_top DUT (
      .clk        (clk),
      .rst        (rst),
      .cfg_we     (cfg_we),
      .cfg_addr   (cfg_addr),
      .cfg_data   (cfg_data),
      .cfg_commit (cfg_commit),
      .din_ld     (din_ld),
      .din_a      (din_a),
      .din_b      (din_b),
      .run        (run),
      .dout       (dout),
      .out_valid  (out_valid)
   );

   flow_checker chk (
      .clk       (clk),
      .rst       (rst),
      .dout      (dout),
      .out_valid (out_valid),
      .test_num  (cur_test),
      .step_mode (cur_step),
      .expected  (cur_exp),
      .exp_valid (cur_valid),
      .test_end  (test_end),
      .all_done  (all_done),
      .n_pass    (n_pass),
      .n_fail    (n_fail)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [alu_conf_w-1:0] conf_of(input int sela, input int selb,
                                                     input int loop,
                                                     input logic [fns_w-1:0] fn);
      return {sela[slot_w-1:0], selb[slot_w-1:0], loop[0], fn};
   endfunction

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_word(output logic [data_w-1:0] w);
      w = '0;
      for (int i = 0; i < data_w; i++) begin
         lfsr = lfsr_next(lfsr);
         w = {w[data_w-2:0], lfsr[0]};
      end
   endtask

   // reference for the plain two-operand functions
   function automatic logic [data_w-1:0] model_result(input logic [fns_w-1:0] fn,
                                                      input logic [data_w-1:0] a,
                                                      input logic [data_w-1:0] b);
      case (fn)
         fn_add: return a + b;
         fn_sub: return b - a;
         fn_or:  return a | b;
         fn_and: return a & b;
         default: return 'x;
      endcase
   endfunction

   task automatic add_row(input logic [alu_conf_w-1:0] c0, input logic [alu_conf_w-1:0] c1,
                          input logic [slot_w-1:0] osel, input logic [data_w-1:0] a,
                          input logic [data_w-1:0] b, input int len, input int mode,
                          input logic commit, input logic [data_w-1:0] exp);
      row_c0[n_rows]     = c0;
      row_c1[n_rows]     = c1;
      row_osel[n_rows]   = osel;
      row_a[n_rows]      = a;
      row_b[n_rows]      = b;
      row_len[n_rows]    = len;
      row_mode[n_rows]   = mode;
      row_commit[n_rows] = commit;
      row_exp[n_rows]    = exp;
      n_rows++;
   endtask

   task automatic apply_row(input int i);
      logic [data_w-1:0] a;
      logic [data_w-1:0] b;
      logic [data_w-1:0] exp;
      a   = row_a[i];
      b   = row_b[i];
      exp = row_exp[i];
      if (row_mode[i] == mode_model) begin
         draw_word(a);
         draw_word(b);
         exp = model_result(row_exp[i][fns_w-1:0], a, b);
      end
      // configuration only changes with run low
      @(posedge clk);
      cfg_we   <= 1'b1;
      cfg_addr <= cfg_alu0;
      cfg_data <= row_c0[i];
      @(posedge clk);
      cfg_addr <= cfg_alu1;
      cfg_data <= row_c1[i];
      @(posedge clk);
      cfg_addr <= cfg_out;
      cfg_data <= {{(alu_conf_w-slot_w){1'b0}}, row_osel[i]};
      @(posedge clk);
      cfg_we     <= 1'b0;
      cfg_commit <= row_commit[i];
      din_ld     <= 1'b1;
      din_a      <= a;
      din_b      <= b;
      @(posedge clk);
      cfg_commit <= 1'b0;
      din_ld     <= 1'b0;
      run        <= 1'b1;
      cur_test   <= i;
      cur_step   <= (row_mode[i] == mode_step);
      cur_exp    <= exp;
      // out_valid covers the run cycles after the fill
      cur_valid  <= row_len[i] - out_fill;
      repeat (row_len[i]) @(posedge clk);
      run      <= 1'b0;
      test_end <= 1'b1;
      @(posedge clk);
      test_end <= 1'b0;
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial begin
      rst        = 1'b1;
      cfg_we     = 1'b0;
      cfg_addr   = '0;
      cfg_data   = '0;
      cfg_commit = 1'b0;
      din_ld     = 1'b0;
      din_a      = '0;
      din_b      = '0;
      run        = 1'b0;
      cur_test   = 0;
      cur_step   = 1'b0;
      cur_exp    = '0;
      cur_valid  = 0;
      test_end   = 1'b0;
      all_done   = 1'b0;
      lfsr       = 32'h07ce_270a;
      n_rows     = 0;
      cycle_cnt  = 0;
      cycle_limit = 0;

      // add, sub, or, and on random operands
      add_row(conf_of(0, 1, 0, fn_add), 0, 2, 0, 0, 10, mode_model, 1, fn_add);
      add_row(conf_of(0, 1, 0, fn_sub), 0, 2, 0, 0, 10, mode_model, 1, fn_sub);
      add_row(conf_of(0, 1, 0, fn_or), 0, 2, 0, 0, 10, mode_model, 1, fn_or);
      add_row(conf_of(0, 1, 0, fn_and), 0, 2, 0, 0, 10, mode_model, 1, fn_and);
      // signed compare, max, min
      add_row(conf_of(0, 1, 0, fn_cmp_sig), 0, 2, 5, 3, 10, mode_fixed, 1, 32'hffff_fffe);
      add_row(conf_of(0, 1, 0, fn_cmp_sig), 0, 2, -1, 1, 10, mode_fixed, 1, 32'h0000_0002);
      add_row(conf_of(0, 1, 0, fn_cmp_sig), 0, 2, 32'h7fff_ffff, 32'h8000_0000,
              10, mode_fixed, 1, 32'h8000_0001);
      add_row(conf_of(0, 1, 0, fn_cmp_sig), 0, 2, 32'h8000_0000, 32'h8000_0000,
              10, mode_fixed, 1, 32'h0000_0000);
      add_row(conf_of(0, 1, 0, fn_max), 0, 2, -5, 3, 10, mode_fixed, 1, 32'h0000_0003);
      add_row(conf_of(0, 1, 0, fn_max), 0, 2, 7, -2, 10, mode_fixed, 1, 32'h0000_0007);
      add_row(conf_of(0, 1, 0, fn_max), 0, 2, 32'h1234_5678, 32'h1234_5678,
              10, mode_fixed, 1, 32'h1234_5678);
      add_row(conf_of(0, 1, 0, fn_min), 0, 2, -5, 3, 10, mode_fixed, 1, 32'hffff_fffb);
      add_row(conf_of(0, 1, 0, fn_min), 0, 2, 32'h7fff_ffff, 32'h8000_0000,
              10, mode_fixed, 1, 32'h8000_0000);
      // select on bit 31 of a
      add_row(conf_of(0, 1, 0, fn_mux), 0, 2, 32'h8000_0001, 32'hcafe_f00d,
              10, mode_fixed, 1, 32'hcafe_f00d);
      add_row(conf_of(0, 1, 0, fn_mux), 0, 2, 32'h7fff_ffff, 32'hcafe_f00d,
              10, mode_fixed, 1, 32'h0000_0000);
      // alu1 consumes alu0
      add_row(conf_of(0, 1, 0, fn_add), conf_of(0, 2, 0, fn_sub), 3,
              32'h1111_1111, 32'h0f0f_0f0f, 10, mode_fixed, 1, 32'h0f0f_0f0f);
      add_row(conf_of(0, 1, 0, fn_add), conf_of(1, 2, 0, fn_max), 3,
              5, 10, 10, mode_fixed, 1, 32'h0000_000f);
      // accumulate b every cycle and wrap mod 2**32
      add_row(conf_of(0, 1, 1, fn_add), 0, 2, 1, 32'h9000_0003, 16, mode_step, 1,
              32'h9000_0003);
      // shadow write without commit and then with it
      add_row(conf_of(0, 1, 0, fn_add), 0, 2, 32'h100, 32'h23, 10, mode_fixed, 1, 32'h123);
      add_row(conf_of(0, 1, 0, fn_and), 0, 2, 32'hf0, 32'hff, 10, mode_fixed, 0, 32'h1ef);
      add_row(conf_of(0, 1, 0, fn_and), 0, 2, 32'hf0, 32'hff, 10, mode_fixed, 1, 32'hf0);

      for (int i = 0; i < n_rows; i++)
         cycle_limit += row_len[i] + 20;

      repeat (2) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < n_rows; i++)
         apply_row(i);
      all_done <= 1'b1;
      repeat (2) @(posedge clk);
      if (n_fail == 0 && n_pass == n_rows)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
hw/flow_pkg.sv
hw/cfg_bank.sv
hw/flow_in_stage.sv
hw/alu_lite.sv
hw/flow_out_stage.sv
hw/flow_top.sv
tb/flow_checker.sv
tb/tb_flow_top.sv
